// File: design/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

`default_nettype none

// on-chip ram depth in 32-bit words
`define SOC_RAM_WORDS 256

// word address bits that index the ram
`define SOC_RAM_AW 8

// first word address past the ram
// ram answers everything below this
`define SOC_RAM_LIMIT 30'd256

// boot image length in words
`define SOC_BOOT_WORDS 16

// serial transmitter word address, byte address 0x3800_0000
`define SOC_UART_ADR 30'h0E000000

// clocks per serial bit
`define SOC_UART_DIV 8

`default_nettype wire

`endif

// File: design/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// one bus data word
	typedef logic [31:0] word_t;

	// word address, byte address bits 31..2
	// low two bits are replaced by sel
	typedef logic [29:0] wadr_t;

	// byte lane selects
	// bit 3 picks bits 31..24, bit 0 picks bits 7..0
	typedef logic [3:0] sel_t;

	// serial payload
	typedef logic [7:0] byte_t;

endpackage

`default_nettype wire

// File: design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// boot loader: fetch from storage, store to ram, repeat
	typedef enum logic [1:0] {
		BOOT_IDLE,
		BOOT_READ,
		BOOT_WRITE,
		BOOT_DONE
	} boot_state_t;

	// 8N1 transmitter frame phases
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

`default_nettype wire

// File: design/serial_txd.sv
`include "soc_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module serial_txd import bus_pkg::*, ctrl_pkg::*; (
	input  wire         clk_i,
	input  wire         arst_n_i,
	input  wire         stb_i,
	input  wire byte_t  byte_i,
	output logic        ack_o,
	output logic        txd_o
);

	localparam int BAUD_W = $clog2(`SOC_UART_DIV);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`SOC_UART_DIV - 1);

	tx_state_t         state_q;
	logic [BAUD_W-1:0] baud_q;
	logic [2:0]        bit_q;
	byte_t             shift_q;
	logic              ack_q;
	logic              bit_end;

	// last clock of the current bit
	assign bit_end = (baud_q == BAUD_LAST);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= TX_IDLE;
			baud_q  <= '0;
			bit_q   <= '0;
			ack_q   <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			if (state_q == TX_IDLE || bit_end)
				baud_q <= '0;
			else
				baud_q <= baud_q + 1'b1;
			case (state_q)
				// accept only here, busy requests wait for the stop bit
				TX_IDLE: begin
					bit_q <= '0;
					if (stb_i) begin
						ack_q   <= 1'b1;
						state_q <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end)
						state_q <= TX_DATA;
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_q <= bit_q + 1'b1;
						if (bit_q == 3'd7)
							state_q <= TX_STOP;
					end
				end
				default: begin
					if (bit_end)
						state_q <= TX_IDLE;
				end
			endcase
		end
	end

	// payload, lsb goes out first
	always_ff @(posedge clk_i) begin
		if (state_q == TX_IDLE && stb_i)
			shift_q <= byte_i;
		else if (state_q == TX_DATA && bit_end)
			shift_q <= {1'b0, shift_q[7:1]};
	end

	// line level per frame phase, high when idle
	always_comb begin
		case (state_q)
			TX_START: txd_o = 1'b0;
			TX_DATA:  txd_o = shift_q[0];
			default:  txd_o = 1'b1;
		endcase
	end

	assign ack_o = ack_q;

endmodule

`default_nettype wire

// File: design/onchip_ram.sv
`include "soc_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module onchip_ram import bus_pkg::*; (
	input  wire         clk_i,
	input  wire         arst_n_i,
	input  wire         cyc_i,
	input  wire         stb_i,
	input  wire         we_i,
	input  wire wadr_t  adr_i,
	input  wire sel_t   sel_i,
	input  wire word_t  dat_i,
	output word_t       dat_o,
	output logic        ack_o
);

	word_t                  mem_q [`SOC_RAM_WORDS];
	word_t                  rdat_q;
	logic                   ack_q;
	logic                   req;
	logic [`SOC_RAM_AW-1:0] idx;

	// new request only while no ack is out
	assign req = cyc_i & stb_i & ~ack_q;
	// upper bits already decoded by the switch
	assign idx = adr_i[`SOC_RAM_AW-1:0];

	always_ff @(posedge clk_i) begin
		if (req) begin
			// read before write, data lines up with ack
			rdat_q <= mem_q[idx];
			if (we_i) begin
				for (int i = 0; i < 4; i++) begin
					if (sel_i[i])
						mem_q[idx][8*i +: 8] <= dat_i[8*i +: 8];
				end
			end
		end
	end

	// one cycle after stb, cleared after it pulses
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req;
	end

	assign ack_o = ack_q;
	assign dat_o = rdat_q;

endmodule

`default_nettype wire

// File: design/early_boot.sv
`include "soc_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module early_boot import bus_pkg::*, ctrl_pkg::*; (
	input  wire         clk_i,
	input  wire         arst_n_i,

	// storage master
	output logic        stor_cyc_o,
	output logic        stor_stb_o,
	output wadr_t       stor_adr_o,
	input  wire word_t  stor_dat_i,
	input  wire         stor_ack_i,

	// ram master
	output logic        boot_cyc_o,
	output logic        boot_stb_o,
	output logic        boot_we_o,
	output wadr_t       boot_adr_o,
	output sel_t        boot_sel_o,
	output word_t       boot_dat_o,
	input  wire         boot_ack_i,

	output logic        boot_done_o
);

	localparam wadr_t LAST_WORD = wadr_t'(`SOC_BOOT_WORDS - 1);

	boot_state_t state_q;
	// current image word, same index on both sides
	wadr_t       word_cnt_q;
	// word fetched from storage, waiting for the ram write
	word_t       hold_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= BOOT_IDLE;
			word_cnt_q <= '0;
		end else begin
			case (state_q)
				// one idle cycle out of reset
				BOOT_IDLE: state_q <= BOOT_READ;
				BOOT_READ: begin
					if (stor_ack_i)
						state_q <= BOOT_WRITE;
				end
				BOOT_WRITE: begin
					if (boot_ack_i) begin
						if (word_cnt_q == LAST_WORD) begin
							state_q <= BOOT_DONE;
						end else begin
							word_cnt_q <= word_cnt_q + 1'b1;
							state_q    <= BOOT_READ;
						end
					end
				end
				// stays here until reset
				default: state_q <= BOOT_DONE;
			endcase
		end
	end

	// capture storage data with its ack
	always_ff @(posedge clk_i) begin
		if (state_q == BOOT_READ && stor_ack_i)
			hold_q <= stor_dat_i;
	end

	// strobes follow state, so they drop the cycle after ack
	assign stor_cyc_o = (state_q == BOOT_READ);
	assign stor_stb_o = (state_q == BOOT_READ);
	assign stor_adr_o = word_cnt_q;

	// full-word writes only
	assign boot_cyc_o = (state_q == BOOT_WRITE);
	assign boot_stb_o = (state_q == BOOT_WRITE);
	assign boot_we_o  = (state_q == BOOT_WRITE);
	assign boot_adr_o = word_cnt_q;
	assign boot_sel_o = 4'hF;
	assign boot_dat_o = hold_q;

	assign boot_done_o = (state_q == BOOT_DONE);

endmodule

`default_nettype wire

// File: design/bus_switch.sv
`include "soc_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module bus_switch import bus_pkg::*; (
	input  wire         clk_i,
	input  wire         arst_n_i,
	input  wire         boot_done_i,

	// boot master, writes only
	input  wire         boot_cyc_i,
	input  wire         boot_stb_i,
	input  wire         boot_we_i,
	input  wire wadr_t  boot_adr_i,
	input  wire sel_t   boot_sel_i,
	input  wire word_t  boot_dat_i,
	output logic        boot_ack_o,

	// host master
	input  wire         host_cyc_i,
	input  wire         host_stb_i,
	input  wire         host_we_i,
	input  wire wadr_t  host_adr_i,
	input  wire sel_t   host_sel_i,
	input  wire word_t  host_dat_i,
	output word_t       host_dat_o,
	output logic        host_ack_o,
	output logic        host_err_o,

	// ram slave
	output logic        ram_cyc_o,
	output logic        ram_stb_o,
	output logic        ram_we_o,
	output wadr_t       ram_adr_o,
	output sel_t        ram_sel_o,
	output word_t       ram_dat_o,
	input  wire word_t  ram_dat_i,
	input  wire         ram_ack_i,

	// serial transmitter slave
	output logic        tx_stb_o,
	output byte_t       tx_byte_o,
	input  wire         tx_ack_i
);

	logic host_req;
	logic hit_ram;
	logic hit_tx;
	logic err_q;

	// host is invisible until the image is in ram, so it just stalls
	assign host_req = boot_done_i & host_cyc_i & host_stb_i;

	// address map
	assign hit_ram = (host_adr_i < `SOC_RAM_LIMIT);
	assign hit_tx  = (host_adr_i == `SOC_UART_ADR);

	// ram sees exactly one master at a time
	assign ram_cyc_o = boot_done_i ? (host_cyc_i & hit_ram) : boot_cyc_i;
	assign ram_stb_o = boot_done_i ? (host_stb_i & hit_ram) : boot_stb_i;
	assign ram_we_o  = boot_done_i ? host_we_i  : boot_we_i;
	assign ram_adr_o = boot_done_i ? host_adr_i : boot_adr_i;
	assign ram_sel_o = boot_done_i ? host_sel_i : boot_sel_i;
	assign ram_dat_o = boot_done_i ? host_dat_i : boot_dat_i;

	// ram ack goes back to whoever owns the bus
	assign boot_ack_o = ~boot_done_i & ram_ack_i;

	assign tx_stb_o = host_req & hit_tx;

	// serial byte from the highest selected lane
	always_comb begin
		if (host_sel_i[3])
			tx_byte_o = host_dat_i[31:24];
		else if (host_sel_i[2])
			tx_byte_o = host_dat_i[23:16];
		else if (host_sel_i[1])
			tx_byte_o = host_dat_i[15:8];
		else if (host_sel_i[0])
			tx_byte_o = host_dat_i[7:0];
		else
			tx_byte_o = 8'hFF;
	end

	assign host_ack_o = boot_done_i & ((hit_ram & ram_ack_i) | (hit_tx & tx_ack_i));
	assign host_dat_o = hit_ram ? ram_dat_i : '0;

	// unmapped address, one-cycle error the cycle after stb
	// err_q term keeps it from repeating while the master still holds stb
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			err_q <= 1'b0;
		else
			err_q <= host_req & ~hit_ram & ~hit_tx & ~err_q;
	end

	assign host_err_o = err_q;

endmodule

`default_nettype wire

// File: design/soc_for_boot.sv
`timescale 1ns/1ps
`default_nettype none

module soc_for_boot import bus_pkg::*; (
	input  wire         clk_i,
	input  wire         arst_n_i,

	// block storage port, word reads only
	output logic        stor_cyc_o,
	output logic        stor_stb_o,
	output wadr_t       stor_adr_o,
	input  wire word_t  stor_dat_i,
	input  wire         stor_ack_i,

	// host master port, stands in for the cpu
	input  wire         host_cyc_i,
	input  wire         host_stb_i,
	input  wire         host_we_i,
	input  wire wadr_t  host_adr_i,
	input  wire sel_t   host_sel_i,
	input  wire word_t  host_dat_i,
	output word_t       host_dat_o,
	output logic        host_ack_o,
	output logic        host_err_o,

	output logic        boot_done_o,
	output logic        uart_txd_o
);

	// boot master to switch
	logic  boot_cyc;
	logic  boot_stb;
	logic  boot_we;
	wadr_t boot_adr;
	sel_t  boot_sel;
	word_t boot_dat;
	logic  boot_ack;

	// switch to ram slave
	logic  ram_cyc;
	logic  ram_stb;
	logic  ram_we;
	wadr_t ram_adr;
	sel_t  ram_sel;
	word_t ram_wdat;
	word_t ram_rdat;
	logic  ram_ack;

	// switch to serial transmitter
	logic  tx_stb;
	byte_t tx_byte;
	logic  tx_ack;

	// copies the image, then releases the bus to the host
	early_boot m_early_boot (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.stor_cyc_o  (stor_cyc_o),
		.stor_stb_o  (stor_stb_o),
		.stor_adr_o  (stor_adr_o),
		.stor_dat_i  (stor_dat_i),
		.stor_ack_i  (stor_ack_i),
		.boot_cyc_o  (boot_cyc),
		.boot_stb_o  (boot_stb),
		.boot_we_o   (boot_we),
		.boot_adr_o  (boot_adr),
		.boot_sel_o  (boot_sel),
		.boot_dat_o  (boot_dat),
		.boot_ack_i  (boot_ack),
		.boot_done_o (boot_done_o)
	);

	// master select and address decode
	bus_switch m_bus_switch (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.boot_done_i (boot_done_o),
		.boot_cyc_i  (boot_cyc),
		.boot_stb_i  (boot_stb),
		.boot_we_i   (boot_we),
		.boot_adr_i  (boot_adr),
		.boot_sel_i  (boot_sel),
		.boot_dat_i  (boot_dat),
		.boot_ack_o  (boot_ack),
		.host_cyc_i  (host_cyc_i),
		.host_stb_i  (host_stb_i),
		.host_we_i   (host_we_i),
		.host_adr_i  (host_adr_i),
		.host_sel_i  (host_sel_i),
		.host_dat_i  (host_dat_i),
		.host_dat_o  (host_dat_o),
		.host_ack_o  (host_ack_o),
		.host_err_o  (host_err_o),
		.ram_cyc_o   (ram_cyc),
		.ram_stb_o   (ram_stb),
		.ram_we_o    (ram_we),
		.ram_adr_o   (ram_adr),
		.ram_sel_o   (ram_sel),
		.ram_dat_o   (ram_wdat),
		.ram_dat_i   (ram_rdat),
		.ram_ack_i   (ram_ack),
		.tx_stb_o    (tx_stb),
		.tx_byte_o   (tx_byte),
		.tx_ack_i    (tx_ack)
	);

	onchip_ram m_onchip_ram (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.cyc_i    (ram_cyc),
		.stb_i    (ram_stb),
		.we_i     (ram_we),
		.adr_i    (ram_adr),
		.sel_i    (ram_sel),
		.dat_i    (ram_wdat),
		.dat_o    (ram_rdat),
		.ack_o    (ram_ack)
	);

	serial_txd m_serial_txd (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.stb_i    (tx_stb),
		.byte_i   (tx_byte),
		.ack_o    (tx_ack),
		.txd_o    (uart_txd_o)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk_o,
	output logic arst_n_o
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset low for two rising edges, released on a falling edge
	initial begin
		arst_n_o = 1'b0;
		repeat (2) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/soc_assert.sv
`timescale 1ns/1ps
`default_nettype none

module soc_assert (
	input wire clk_i,
	input wire arst_n_i,
	input wire boot_done_i,
	input wire boot_ack_i,
	input wire host_ack_i,
	input wire host_err_i
);

	// a host cycle ends with ack or err, never both
	ack_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(host_ack_i && host_err_i))
		else $error("host ack and host err high in the same cycle");

	// host ack only answers a request made after boot done
	no_early_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		host_ack_i |-> $past(boot_done_i))
		else $error("host ack before boot done");

	// every ack is a single-cycle pulse
	host_ack_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		host_ack_i |=> !host_ack_i)
		else $error("host ack longer than one cycle");

	boot_ack_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		boot_ack_i |=> !boot_ack_i)
		else $error("boot ack longer than one cycle");

endmodule

bind bus_switch soc_assert m_soc_assert (
	.clk_i       (clk_i),
	.arst_n_i    (arst_n_i),
	.boot_done_i (boot_done_i),
	.boot_ack_i  (boot_ack_o),
	.host_ack_i  (host_ack_o),
	.host_err_i  (host_err_o)
);

`default_nettype wire

// File: testbench/soc_tb.sv
`include "soc_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module soc_tb import bus_pkg::*; ();

	// op codes, first column of an op row
	localparam word_t OP_END       = 32'd0;
	localparam word_t OP_READ      = 32'd1;
	localparam word_t OP_WRITE     = 32'd2;
	localparam word_t OP_SERIAL    = 32'd3;
	localparam word_t OP_BAD_READ  = 32'd4;
	localparam word_t OP_BAD_WRITE = 32'd5;
	localparam int PAT_WORDS = 256;
	localparam logic [31:0] RNG_SEED = 32'h1021_01cc;

	logic  clk;
	logic  arst_n;
	logic  stor_cyc;
	logic  stor_stb;
	wadr_t stor_adr;
	word_t stor_dat;
	logic  stor_ack;
	logic  host_cyc;
	logic  host_stb;
	logic  host_we;
	wadr_t host_adr;
	sel_t  host_sel;
	word_t host_wdat;
	word_t host_rdat;
	logic  host_ack;
	logic  host_err;
	logic  boot_done;
	logic  uart_txd;

	// image words first, then op rows of five words
	word_t pat_mem [PAT_WORDS];
	int    n_ops;
	bit    patterns_loaded;
	int    errors;
	int    tests_run;
	int    tests_failed;
	int    serial_acks;
	int    frames_done;
	// bytes still expected on the serial line, oldest first
	byte_t exp_bytes [$];

	tb_clkgen m_clkgen (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	soc_for_boot dut0 (
		.clk_i       (clk),
		.arst_n_i    (arst_n),
		.stor_cyc_o  (stor_cyc),
		.stor_stb_o  (stor_stb),
		.stor_adr_o  (stor_adr),
		.stor_dat_i  (stor_dat),
		.stor_ack_i  (stor_ack),
		.host_cyc_i  (host_cyc),
		.host_stb_i  (host_stb),
		.host_we_i   (host_we),
		.host_adr_i  (host_adr),
		.host_sel_i  (host_sel),
		.host_dat_i  (host_wdat),
		.host_dat_o  (host_rdat),
		.host_ack_o  (host_ack),
		.host_err_o  (host_err),
		.boot_done_o (boot_done),
		.uart_txd_o  (uart_txd)
	);

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic close_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED", tests_run, name);
		end
	endtask

	// image plus op rows, op count ends at the first end row
	task automatic load_patterns();
		int idx;
		$readmemh("testbench/soc_patterns.hex", pat_mem);
		n_ops = 0;
		idx = `SOC_BOOT_WORDS;
		while (idx + 4 < PAT_WORDS && pat_mem[idx] != OP_END) begin
			n_ops++;
			idx += 5;
		end
		patterns_loaded = 1'b1;
	endtask

	// one host cycle, holds stb until ack or err
	task automatic bus_cycle(input logic we, input wadr_t adr, input sel_t sel,
		input word_t wdat, output word_t rdat, output logic ack, output logic err);
		logic done;
		@(negedge clk);
		host_cyc  = 1'b1;
		host_stb  = 1'b1;
		host_we   = we;
		host_adr  = adr;
		host_sel  = sel;
		host_wdat = wdat;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			done = (host_ack === 1'b1) || (host_err === 1'b1);
		end
		rdat = host_rdat;
		ack  = host_ack;
		err  = host_err;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we  = 1'b0;
	endtask

	// block storage, 0 to 3 cycles of latency per word
	initial begin : storage_model
		int lat;
		stor_ack = 1'b0;
		stor_dat = '0;
		void'($urandom(RNG_SEED));
		forever begin
			@(negedge clk);
			if (stor_cyc && stor_stb && !stor_ack) begin
				lat = int'($urandom % 32'd4);
				repeat (lat) @(negedge clk);
				stor_dat = pat_mem[stor_adr[7:0]];
				stor_ack = 1'b1;
				@(negedge clk);
				stor_ack = 1'b0;
				stor_dat = '0;
			end
		end
	end

	// 8N1 receiver, samples each bit in its middle
	initial begin : uart_decoder
		byte_t got;
		int    i;
		forever begin
			@(negedge clk);
			if (arst_n === 1'b1 && uart_txd === 1'b0) begin
				repeat (`SOC_UART_DIV / 2) @(negedge clk);
				if (uart_txd !== 1'b0) begin
					$display("serial start bit too short at %0t ns", $time);
					errors++;
				end
				for (i = 0; i < 8; i++) begin
					repeat (`SOC_UART_DIV) @(negedge clk);
					got[i] = uart_txd;
				end
				repeat (`SOC_UART_DIV) @(negedge clk);
				if (uart_txd !== 1'b1) begin
					$display("serial stop bit missing at %0t ns", $time);
					errors++;
				end
				if (exp_bytes.size() == 0) begin
					$display("serial frame %h at %0t ns with no write behind it", got, $time);
					errors++;
				end else begin
					check_byte("serial frame", got, exp_bytes.pop_front());
				end
				frames_done++;
			end
		end
	end

	// limit from boot length plus one frame time per op
	initial begin : watchdog
		int limit;
		wait (patterns_loaded);
		limit = `SOC_BOOT_WORDS * 10
			+ (n_ops + `SOC_BOOT_WORDS + 4) * (10 * `SOC_UART_DIV + 4) + 500;
		repeat (limit) @(posedge clk);
		$display("TIMEOUT: run still going after %0d clock cycles", limit);
		$display("Some tests failed");
		$finish;
	end

	initial begin : main
		word_t rdat;
		logic  ack;
		logic  err;
		int    k;
		int    op;
		int    base;
		int    errs0;
		word_t kind;
		wadr_t adr;
		sel_t  sel;
		word_t wdat;
		word_t expv;
		string name;
		host_cyc  = 1'b0;
		host_stb  = 1'b0;
		host_we   = 1'b0;
		host_adr  = '0;
		host_sel  = '0;
		host_wdat = '0;
		load_patterns();
		@(posedge arst_n);
		@(negedge clk);

		// host read issued while the boot master still owns the bus
		errs0 = errors;
		check_flag("boot_done after reset", boot_done, 1'b0);
		bus_cycle(1'b0, '0, 4'hF, '0, rdat, ack, err);
		check_flag("boot_done at first host ack", boot_done, 1'b1);
		check_flag("err on early read", err, 1'b0);
		check_word("early read of word 0", rdat, pat_mem[0]);
		close_test("host stalls until boot done", errs0);

		errs0 = errors;
		for (k = 0; k < `SOC_BOOT_WORDS; k++) begin
			bus_cycle(1'b0, wadr_t'(k), 4'hF, '0, rdat, ack, err);
			check_flag("image read ack", ack, 1'b1);
			check_word($sformatf("image word %0d", k), rdat, pat_mem[k]);
		end
		close_test("boot image in ram", errs0);

		for (op = 0; op < n_ops; op++) begin
			base = `SOC_BOOT_WORDS + 5 * op;
			kind = pat_mem[base];
			adr  = pat_mem[base + 1][29:0];
			sel  = pat_mem[base + 2][3:0];
			wdat = pat_mem[base + 3];
			expv = pat_mem[base + 4];
			errs0 = errors;
			case (kind)
				OP_READ: begin
					name = "read";
					bus_cycle(1'b0, adr, sel, wdat, rdat, ack, err);
					check_flag("read ack", ack, 1'b1);
					check_word("read data", rdat, expv);
				end
				OP_WRITE: begin
					name = "write";
					bus_cycle(1'b1, adr, sel, wdat, rdat, ack, err);
					check_flag("write ack", ack, 1'b1);
				end
				OP_SERIAL: begin
					name = "serial write";
					bus_cycle(1'b1, adr, sel, wdat, rdat, ack, err);
					check_flag("serial ack", ack, 1'b1);
					// back-pressure: earlier frames must be done by now
					if (frames_done != serial_acks) begin
						$display("serial ack at %0t ns came before the previous frame ended",
							$time);
						errors++;
					end
					serial_acks++;
					exp_bytes.push_back(expv[7:0]);
				end
				OP_BAD_READ, OP_BAD_WRITE: begin
					name = (kind == OP_BAD_READ) ? "unmapped read" : "unmapped write";
					bus_cycle(kind == OP_BAD_WRITE, adr, sel, wdat, rdat, ack, err);
					check_flag("unmapped err", err, expv[0]);
					check_flag("unmapped ack", ack, 1'b0);
				end
				default: begin
					name = "unknown op";
					$display("pattern row %0d has unknown op code %h", op, kind);
					errors++;
				end
			endcase
			close_test($sformatf("%s %h", name, adr), errs0);
		end

		// every accepted byte has left on the line, in order
		errs0 = errors;
		wait (frames_done == serial_acks);
		close_test("serial frames in order", errs0);

		$display("tests run: %0d, failed: %0d, check errors: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/soc_patterns.hex
// boot image: 16 words, ram words 0 to 15
// then op rows: kind adr sel data expected, kind 1 rd 2 wr 3 serial 4/5 unmapped, 0 ends
13579bdf 2468ace0 deadbeef 01234567
89abcdef a5a5a5a5 5a5a5a5a 0f1e2d3c
4b5a6978 8796a5b4 c3d2e1f0 ffffffff
00000000 11223344 55667788 99aabbcc
00000002 00000003 00000005 aabbccdd 00000000
00000001 00000003 0000000f 00000000 01bb45dd
00000002 00000040 0000000f cafef00d 00000000
00000002 00000040 00000008 11223344 00000000
00000001 00000040 0000000f 00000000 11fef00d
00000002 0000000f 00000006 00abcd00 00000000
00000001 0000000f 0000000f 00000000 99abcdcc
00000002 000000ff 0000000f 5555aaaa 00000000
00000001 000000ff 0000000f 00000000 5555aaaa
00000003 0e000000 0000000f 41424344 00000041
00000003 0e000000 00000003 12345a37 0000005a
00000003 0e000000 00000000 12345678 000000ff
00000004 00000100 0000000f 00000000 00000001
00000005 0e000001 0000000f deadbeef 00000001
00000004 3fffffff 0000000f 00000000 00000001
00000000 00000000 00000000 00000000 00000000

// File: filelist.f
+incdir+design
design/bus_pkg.sv
design/ctrl_pkg.sv
design/serial_txd.sv
design/onchip_ram.sv
design/early_boot.sv
design/bus_switch.sv
design/soc_for_boot.sv
testbench/tb_clkgen.sv
testbench/soc_assert.sv
testbench/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module soc_tb -f filelist.f -o soc_sim

if ./obj_dir/soc_sim > sim.log 2>&1; then
	sim_status=0
else
	sim_status=1
fi
cat sim.log

if grep -q "Some tests failed" sim.log || [ "$sim_status" -ne 0 ]; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"
